// ==== Makefile ====
# Verilator flow for the vector issue sequencer
TOP = vseq_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "STATUS: PASS" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== design/seq_ctrl.sv ====
// Issue fields and response data are valid only in the cycle their strobe is high
`timescale 1ns/1ps
`default_nettype none

module seq_ctrl import vseq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                req_valid_i,
  input  wire op_e                 req_op_i,
  output logic                     req_ready_o,
  input  wire logic                id_full_i,
  input  wire logic [VID_W-1:0]    free_id_i,
  input  wire logic [NR_UNITS-1:0] unit_ready_i,
  input  wire logic [NR_VINSN-1:0] hazard_i,
  input  wire logic                scalar_valid_i,
  input  wire logic [SCALAR_W-1:0] scalar_data_i,
  output logic                     accept_o,
  output logic                     issue_valid_o,
  output logic      [VID_W-1:0]    issue_id_o,
  output op_e                      issue_op_o,
  output logic      [NR_VINSN-1:0] issue_hazard_o,
  output logic                     resp_valid_o,
  output logic      [SCALAR_W-1:0] resp_data_o
);

  // WAIT holds off new requests until the scalar result returns
  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e state_q;
  state_e state_d;

  logic unit_ok;
  logic slide_stall;

  //////////////////////////////
  // Issue decision
  //////////////////////////////

  assign unit_ok = unit_ready_i[op_unit(req_op_i)];

  // A slide-up cannot chain, so it waits for every dependency to clear
  assign slide_stall = (req_op_i == OP_SLIDEUP) && (|hazard_i);

  assign req_ready_o = (state_q == IDLE) && !id_full_i && unit_ok && !slide_stall;
  assign accept_o    = req_valid_i && req_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept_o && (req_op_i == OP_MVXS)) state_d = WAIT;
      end
      WAIT: begin
        if (scalar_valid_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      issue_valid_o <= 1'b0;
      resp_valid_o  <= 1'b0;
    end else begin
      state_q       <= state_d;
      issue_valid_o <= accept_o;
      resp_valid_o  <= (state_q == WAIT) && scalar_valid_i;
    end
  end

  // Issue payload is captured on accept
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      issue_id_o     <= free_id_i;
      issue_op_o     <= req_op_i;
      issue_hazard_o <= hazard_i;
    end
  end

  // Scalar result becomes the response
  always_ff @(posedge clk_i) begin
    if ((state_q == WAIT) && scalar_valid_i) resp_data_o <= scalar_data_i;
  end

  // A scalar result only arrives for the move that is waiting for it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    scalar_valid_i |-> (state_q == WAIT));

endmodule

`default_nettype wire

// ==== design/unit_queue_cnt.sv ====
// Counts rise only on accept and fall only on the unit's done pulse, one step per cycle
`timescale 1ns/1ps
`default_nettype none

module unit_queue_cnt import vseq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                accept_i,
  input  wire op_e                 req_op_i,
  input  wire logic [NR_UNITS-1:0] unit_done_i,
  output logic      [NR_UNITS-1:0] unit_ready_o
);

  // Unit addressed by the request on the port
  unit_e tgt_unit;
  assign tgt_unit = op_unit(req_op_i);

  //////////////////////////////
  // One counter per unit
  //////////////////////////////

  for (genvar u = 0; u < NR_UNITS; u++) begin : gen_cnt
    logic [CNT_W-1:0] cnt_q;
    logic             cnt_up;
    logic             cnt_down;

    assign cnt_up   = accept_i && (tgt_unit == unit_e'(u));
    assign cnt_down = unit_done_i[u];

    // An issue and a finish in the same cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (cnt_up && !cnt_down) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (cnt_down && !cnt_up) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    // Room is left while the count is below the queue depth
    assign unit_ready_o[u] = cnt_q < CNT_W'(QUEUE_DEPTH[u]);

    // The issue logic must hold requests back once a queue is full
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_q <= CNT_W'(QUEUE_DEPTH[u]));

    // A done pulse always refers to an instruction counted earlier
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_down |-> (cnt_q != '0));
  end

endmodule

`default_nettype wire

// ==== design/vinsn_tracker.sv ====
// Units must not report two done IDs of the same unit in one cycle, since each unit gets one pulse
`timescale 1ns/1ps
`default_nettype none

module vinsn_tracker import vseq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                accept_i,
  input  wire op_e                 req_op_i,
  input  wire logic [NR_VINSN-1:0] vinsn_done_i,
  output logic      [VID_W-1:0]    free_id_o,
  output logic                     id_full_o,
  output logic      [NR_VINSN-1:0] running_o,
  output logic      [NR_UNITS-1:0] unit_done_o,
  output logic                     idle_o
);

  // One bit per ID that is handed out and not yet finished
  logic [NR_VINSN-1:0] running_q;
  // Unit that executes each ID
  unit_e               unit_q [NR_VINSN];

  //////////////////////////////
  // ID allocation
  //////////////////////////////

  // Walk down from the top so that the lowest free ID wins
  always_comb begin
    free_id_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) free_id_o = VID_W'(i);
    end
  end

  assign id_full_o = &running_q;
  assign idle_o    = ~|running_q;
  assign running_o = running_q;

  // An accepted ID is always free, so set and clear never hit the same bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_q & ~vinsn_done_i;
      if (accept_i) running_q[free_id_o] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) unit_q[free_id_o] <= op_unit(req_op_i);
  end

  //////////////////////////////
  // Per-unit done pulses
  //////////////////////////////

  // Only running IDs may count down a queue
  always_comb begin
    unit_done_o = '0;
    for (int i = 0; i < NR_VINSN; i++) begin
      if (vinsn_done_i[i] && running_q[i]) unit_done_o[unit_q[i]] = 1'b1;
    end
  end

  // A unit finishes only what the sequencer issued to it earlier
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (vinsn_done_i & ~running_q) == '0);

endmodule

`default_nettype wire

// ==== design/vreg_scoreboard.sv ====
// Tracks only the latest reader and writer per register, so older readers are covered by chaining
`timescale 1ns/1ps
`default_nettype none

module vreg_scoreboard import vseq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                accept_i,
  input  wire logic [VID_W-1:0]    req_id_i,
  input  wire logic [VREG_W-1:0]   req_vd_i,
  input  wire logic [VREG_W-1:0]   req_vs1_i,
  input  wire logic [VREG_W-1:0]   req_vs2_i,
  input  wire logic                req_use_vd_i,
  input  wire logic                req_use_vs1_i,
  input  wire logic                req_use_vs2_i,
  input  wire logic                req_vm_i,
  input  wire logic [NR_VINSN-1:0] running_i,
  output logic      [NR_VINSN-1:0] hazard_o
);

  localparam logic [VREG_W-1:0] MASK_IDX = VREG_W'(VMASK_REG);

  // Last writer and last reader of every register
  logic [VID_W-1:0]    wr_vid_q [NR_VREGS];
  logic [VID_W-1:0]    rd_vid_q [NR_VREGS];
  logic [NR_VREGS-1:0] wr_vld_q;
  logic [NR_VREGS-1:0] rd_vld_q;
  // Entries whose ID is still running
  logic [NR_VREGS-1:0] wr_live;
  logic [NR_VREGS-1:0] rd_live;

  for (genvar r = 0; r < NR_VREGS; r++) begin : gen_live
    assign wr_live[r] = wr_vld_q[r] & running_i[wr_vid_q[r]];
    assign rd_live[r] = rd_vld_q[r] & running_i[rd_vid_q[r]];
  end

  // One-hot ID vector, empty when the entry is not live
  function automatic logic [NR_VINSN-1:0] id_bit(logic [VID_W-1:0] id, logic en);
    return {{(NR_VINSN - 1){1'b0}}, en} << id;
  endfunction

  //////////////////////////////
  // Hazard vector
  //////////////////////////////

  always_comb begin
    hazard_o = '0;
    // RAW on the sources and on the mask of a masked instruction
    if (req_use_vs1_i) hazard_o |= id_bit(wr_vid_q[req_vs1_i], wr_live[req_vs1_i]);
    if (req_use_vs2_i) hazard_o |= id_bit(wr_vid_q[req_vs2_i], wr_live[req_vs2_i]);
    if (!req_vm_i) hazard_o |= id_bit(wr_vid_q[MASK_IDX], wr_live[MASK_IDX]);
    // WAW and WAR on the destination
    if (req_use_vd_i) begin
      hazard_o |= id_bit(wr_vid_q[req_vd_i], wr_live[req_vd_i]);
      hazard_o |= id_bit(rd_vid_q[req_vd_i], rd_live[req_vd_i]);
    end
  end

  //////////////////////////////
  // List update
  //////////////////////////////

  // Finished entries drop out so a reused ID is not mistaken for the old one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_vld_q <= '0;
      rd_vld_q <= '0;
    end else begin
      wr_vld_q <= wr_live;
      rd_vld_q <= rd_live;
      if (accept_i) begin
        if (req_use_vd_i)  wr_vld_q[req_vd_i]  <= 1'b1;
        if (req_use_vs1_i) rd_vld_q[req_vs1_i] <= 1'b1;
        if (req_use_vs2_i) rd_vld_q[req_vs2_i] <= 1'b1;
        if (!req_vm_i)     rd_vld_q[MASK_IDX]  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      if (req_use_vd_i)  wr_vid_q[req_vd_i]  <= req_id_i;
      if (req_use_vs1_i) rd_vid_q[req_vs1_i] <= req_id_i;
      if (req_use_vs2_i) rd_vid_q[req_vs2_i] <= req_id_i;
      if (!req_vm_i)     rd_vid_q[MASK_IDX]  <= req_id_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/vseq_pkg.sv ====
// Sizes are fixed for eight IDs and 32 registers, and scalar moves are counted on the ALU queue
`default_nettype none

package vseq_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Instructions in flight and the width of their ID
  localparam int NR_VINSN  = 8;
  localparam int VID_W     = 3;

  // Vector register file
  localparam int NR_VREGS  = 32;
  localparam int VREG_W    = 5;
  // Register v0 always holds the mask
  localparam int VMASK_REG = 0;

  localparam int SCALAR_W  = 64;

  // Wide enough to hold the deepest queue
  localparam int CNT_W     = 3;

  //////////////////////////////
  // Units and opcodes
  //////////////////////////////

  // The encoding doubles as the index into per-unit vectors
  typedef enum logic [2:0] {
    UNIT_ALU   = 3'd0,
    UNIT_MUL   = 3'd1,
    UNIT_LOAD  = 3'd2,
    UNIT_STORE = 3'd3,
    UNIT_SLIDE = 3'd4
  } unit_e;

  localparam int NR_UNITS = 5;

  typedef enum logic [2:0] {
    OP_ADD     = 3'd0,
    OP_MUL     = 3'd1,
    OP_LOAD    = 3'd2,
    OP_STORE   = 3'd3,
    OP_SLIDEUP = 3'd4,
    OP_MVXS    = 3'd5
  } op_e;

  // Queue depth of each unit in unit_e order
  localparam int QUEUE_DEPTH [NR_UNITS] = '{4, 4, 2, 2, 1};

  // Scalar moves read their element through the ALU
  function automatic unit_e op_unit(op_e op);
    unit_e unit;
    case (op)
      OP_MUL:     unit = UNIT_MUL;
      OP_LOAD:    unit = UNIT_LOAD;
      OP_STORE:   unit = UNIT_STORE;
      OP_SLIDEUP: unit = UNIT_SLIDE;
      default:    unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

`default_nettype wire

// ==== design/vseq_top.sv ====
// Requests must stay stable until accepted, and issue has no back-pressure toward the units
`timescale 1ns/1ps
`default_nettype none

module vseq_top import vseq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Dispatcher request
  input  wire logic                req_valid_i,
  output logic                     req_ready_o,
  input  wire op_e                 req_op_i,
  input  wire logic [VREG_W-1:0]   req_vd_i,
  input  wire logic [VREG_W-1:0]   req_vs1_i,
  input  wire logic [VREG_W-1:0]   req_vs2_i,
  input  wire logic                req_use_vd_i,
  input  wire logic                req_use_vs1_i,
  input  wire logic                req_use_vs2_i,
  input  wire logic                req_vm_i,
  // Issue toward the units
  output logic                     issue_valid_o,
  output logic      [VID_W-1:0]    issue_id_o,
  output op_e                      issue_op_o,
  output logic      [NR_VINSN-1:0] issue_hazard_o,
  input  wire logic [NR_VINSN-1:0] vinsn_done_i,
  // Scalar result and response
  input  wire logic                scalar_valid_i,
  input  wire logic [SCALAR_W-1:0] scalar_data_i,
  output logic                     resp_valid_o,
  output logic      [SCALAR_W-1:0] resp_data_o,
  output logic                     idle_o
);

  logic                accept;
  logic [VID_W-1:0]    free_id;
  logic                id_full;
  logic [NR_VINSN-1:0] running;
  logic [NR_UNITS-1:0] unit_done;
  logic [NR_UNITS-1:0] unit_ready;
  logic [NR_VINSN-1:0] hazard;

  vinsn_tracker u_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .req_op_i     (req_op_i),
    .vinsn_done_i (vinsn_done_i),
    .free_id_o    (free_id),
    .id_full_o    (id_full),
    .running_o    (running),
    .unit_done_o  (unit_done),
    .idle_o       (idle_o)
  );

  unit_queue_cnt u_queue_cnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .req_op_i     (req_op_i),
    .unit_done_i  (unit_done),
    .unit_ready_o (unit_ready)
  );

  vreg_scoreboard u_scoreboard (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .accept_i      (accept),
    .req_id_i      (free_id),
    .req_vd_i      (req_vd_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_use_vd_i  (req_use_vd_i),
    .req_use_vs1_i (req_use_vs1_i),
    .req_use_vs2_i (req_use_vs2_i),
    .req_vm_i      (req_vm_i),
    .running_i     (running),
    .hazard_o      (hazard)
  );

  seq_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_ready_o    (req_ready_o),
    .id_full_i      (id_full),
    .free_id_i      (free_id),
    .unit_ready_i   (unit_ready),
    .hazard_i       (hazard),
    .scalar_valid_i (scalar_valid_i),
    .scalar_data_i  (scalar_data_i),
    .accept_o       (accept),
    .issue_valid_o  (issue_valid_o),
    .issue_id_o     (issue_id_o),
    .issue_op_o     (issue_op_o),
    .issue_hazard_o (issue_hazard_o),
    .resp_valid_o   (resp_valid_o),
    .resp_data_o    (resp_data_o)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
design/vseq_pkg.sv
design/vinsn_tracker.sv
design/unit_queue_cnt.sv
design/vreg_scoreboard.sv
design/seq_ctrl.sv
design/vseq_top.sv
test/vseq_tb.sv

// ==== test/vseq_tb.sv ====
// Holds one request at a time until accepted, and sends at most one done ID per cycle
`timescale 1ns/1ps
`default_nettype none

module vseq_tb import vseq_pkg::*; ();

  localparam int WAIT_LIMIT = 200;
  localparam int RAND_INSNS = 60;
  // Queue depths in ALU, MUL, LOAD, STORE, SLIDE order
  localparam int DEPTH [5] = '{4, 4, 2, 2, 1};

  logic                clk_i;
  logic                rst_ni;
  logic                req_valid_i;
  logic                req_ready_o;
  op_e                 req_op_i;
  logic [VREG_W-1:0]   req_vd_i;
  logic [VREG_W-1:0]   req_vs1_i;
  logic [VREG_W-1:0]   req_vs2_i;
  logic                req_use_vd_i;
  logic                req_use_vs1_i;
  logic                req_use_vs2_i;
  logic                req_vm_i;
  logic                issue_valid_o;
  logic [VID_W-1:0]    issue_id_o;
  op_e                 issue_op_o;
  logic [NR_VINSN-1:0] issue_hazard_o;
  logic [NR_VINSN-1:0] vinsn_done_i;
  logic                scalar_valid_i;
  logic [SCALAR_W-1:0] scalar_data_i;
  logic                resp_valid_o;
  logic [SCALAR_W-1:0] resp_data_o;
  logic                idle_o;

  vseq_top DUT (.*);

  // Reference state, always one edge ahead of what the DUT shows at a falling edge
  bit  m_running [NR_VINSN];
  int  m_unit    [NR_VINSN];
  int  m_cnt     [5];
  int  m_wr_id   [NR_VREGS];
  int  m_rd_id   [NR_VREGS];
  bit  m_wr_vld  [NR_VREGS];
  bit  m_rd_vld  [NR_VREGS];
  bit  m_wait;

  // Expected issues, popped one edge after the accept
  int                  exp_id_q  [$];
  op_e                 exp_op_q  [$];
  logic [NR_VINSN-1:0] exp_haz_q [$];
  bit                  resp_pend;
  logic [SCALAR_W-1:0] resp_exp;

  int errors;
  int checks;
  int acc_count;
  int acc_mark;
  int last_acc_id;

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int unit_of(op_e op);
    case (op)
      OP_MUL:     return 1;
      OP_LOAD:    return 2;
      OP_STORE:   return 3;
      OP_SLIDEUP: return 4;
      default:    return 0;
    endcase
  endfunction

  function automatic bit wr_live(int r);
    return m_wr_vld[r] && m_running[m_wr_id[r]];
  endfunction

  function automatic bit rd_live(int r);
    return m_rd_vld[r] && m_running[m_rd_id[r]];
  endfunction

  // Lowest free ID, RAW/WAR/WAW vector, and whether the request may go
  function automatic bit ref_issue(op_e op, int vd, int vs1, int vs2, bit uvd, bit uvs1,
                                   bit uvs2, bit vm, output int id,
                                   output logic [NR_VINSN-1:0] haz);
    bit full;
    int u;
    full = 1'b1;
    id   = 0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!m_running[i]) begin
        id   = i;
        full = 1'b0;
      end
    end
    haz = '0;
    if (uvs1 && wr_live(vs1)) haz[m_wr_id[vs1]] = 1'b1;
    if (uvs2 && wr_live(vs2)) haz[m_wr_id[vs2]] = 1'b1;
    if (!vm && wr_live(VMASK_REG)) haz[m_wr_id[VMASK_REG]] = 1'b1;
    if (uvd && wr_live(vd)) haz[m_wr_id[vd]] = 1'b1;
    if (uvd && rd_live(vd)) haz[m_rd_id[vd]] = 1'b1;
    u = unit_of(op);
    return !m_wait && !full && (m_cnt[u] < DEPTH[u]) && !((op == OP_SLIDEUP) && (haz != '0));
  endfunction

  function automatic void model_accept(op_e op, int vd, int vs1, int vs2, bit uvd,
                                       bit uvs1, bit uvs2, bit vm, int id);
    m_running[id] = 1'b1;
    m_unit[id]    = unit_of(op);
    m_cnt[m_unit[id]]++;
    if (uvd) begin
      m_wr_id[vd]  = id;
      m_wr_vld[vd] = 1'b1;
    end
    if (uvs1) begin
      m_rd_id[vs1]  = id;
      m_rd_vld[vs1] = 1'b1;
    end
    if (uvs2) begin
      m_rd_id[vs2]  = id;
      m_rd_vld[vs2] = 1'b1;
    end
    if (!vm) begin
      m_rd_id[VMASK_REG]  = id;
      m_rd_vld[VMASK_REG] = 1'b1;
    end
  endfunction

  // A finished ID drops out of every list, so its reuse starts clean
  function automatic void model_retire(logic [NR_VINSN-1:0] done);
    for (int i = 0; i < NR_VINSN; i++) begin
      if (done[i] && m_running[i]) begin
        m_running[i] = 1'b0;
        m_cnt[m_unit[i]]--;
        for (int r = 0; r < NR_VREGS; r++) begin
          if (m_wr_id[r] == i) m_wr_vld[r] = 1'b0;
          if (m_rd_id[r] == i) m_rd_vld[r] = 1'b0;
        end
      end
    end
  endfunction

  function automatic bit model_idle();
    bit idle;
    idle = 1'b1;
    for (int i = 0; i < NR_VINSN; i++) begin
      if (m_running[i]) idle = 1'b0;
    end
    return idle;
  endfunction

  function automatic void model_reset();
    for (int i = 0; i < NR_VINSN; i++) m_running[i] = 1'b0;
    for (int u = 0; u < 5; u++) m_cnt[u] = 0;
    for (int r = 0; r < NR_VREGS; r++) begin
      m_wr_vld[r] = 1'b0;
      m_rd_vld[r] = 1'b0;
    end
    m_wait = 1'b0;
  endfunction

  //////////////////////////////
  // Compare and report
  //////////////////////////////

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic fail_timeout(string what);
    $display("[TIMEOUT] t=%0t %s within %0d cycles", $time, what, WAIT_LIMIT);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic end_test(string name, int err_before);
    $display("[TEST] %-12s finished with %0d errors", name, errors - err_before);
  endtask

  // Falling edge: compare what the last edge produced, then predict the next edge
  always @(negedge clk_i) begin
    int                  id;
    int                  e_id;
    op_e                 e_op;
    logic [NR_VINSN-1:0] e_haz;
    logic [NR_VINSN-1:0] haz;
    bit                  ok;
    if (rst_ni) begin
      check("issue_valid_o", 64'(issue_valid_o), 64'(exp_id_q.size() != 0));
      if (exp_id_q.size() != 0) begin
        e_id  = exp_id_q.pop_front();
        e_op  = exp_op_q.pop_front();
        e_haz = exp_haz_q.pop_front();
        if (issue_valid_o) begin
          check("issue_id_o", 64'(issue_id_o), 64'(e_id));
          check("issue_op_o", 64'(issue_op_o), 64'(e_op));
          check("issue_hazard_o", 64'(issue_hazard_o), 64'(e_haz));
        end
      end
      check("resp_valid_o", 64'(resp_valid_o), 64'(resp_pend));
      if (resp_pend && resp_valid_o) check("resp_data_o", resp_data_o, resp_exp);
      resp_pend = 1'b0;
      check("idle_o", 64'(idle_o), 64'(model_idle()));
      ok = ref_issue(req_op_i, int'(req_vd_i), int'(req_vs1_i), int'(req_vs2_i), req_use_vd_i,
                     req_use_vs1_i, req_use_vs2_i, req_vm_i, id, haz);
      if (req_valid_i) check("req_ready_o", 64'(req_ready_o), 64'(ok));
      // The scalar result ends WAIT at the coming edge
      if (m_wait && scalar_valid_i) begin
        resp_pend = 1'b1;
        resp_exp  = scalar_data_i;
        m_wait    = 1'b0;
      end
      if (req_valid_i && ok) begin
        exp_id_q.push_back(id);
        exp_op_q.push_back(req_op_i);
        exp_haz_q.push_back(haz);
        model_accept(req_op_i, int'(req_vd_i), int'(req_vs1_i), int'(req_vs2_i), req_use_vd_i,
                     req_use_vs1_i, req_use_vs2_i, req_vm_i, id);
        if (req_op_i == OP_MVXS) m_wait = 1'b1;
        last_acc_id = id;
        acc_count++;
      end
      if (vinsn_done_i != '0) model_retire(vinsn_done_i);
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic start_req(op_e op, int vd, int vs1, int vs2, bit uvd, bit uvs1, bit uvs2,
                           bit vm);
    @(posedge clk_i);
    acc_mark      = acc_count;
    req_valid_i   <= 1'b1;
    req_op_i      <= op;
    req_vd_i      <= VREG_W'(vd);
    req_vs1_i     <= VREG_W'(vs1);
    req_vs2_i     <= VREG_W'(vs2);
    req_use_vd_i  <= uvd;
    req_use_vs1_i <= uvs1;
    req_use_vs2_i <= uvs2;
    req_vm_i      <= vm;
  endtask

  // Returns on the accepting edge and drops valid there
  task automatic wait_accept();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > WAIT_LIMIT) fail_timeout("request was not accepted");
    end while (acc_count == acc_mark);
    req_valid_i <= 1'b0;
  endtask

  task automatic send_req(op_e op, int vd, int vs1, int vs2, bit uvd, bit uvs1, bit uvs2,
                          bit vm);
    start_req(op, vd, vs1, vs2, uvd, uvs1, uvs2, vm);
    wait_accept();
  endtask

  task automatic hold_stalled(int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check("req_ready_o", 64'(req_ready_o), 64'(0));
    end
  endtask

  task automatic retire(int id);
    logic [NR_VINSN-1:0] mask;
    mask     = '0;
    mask[id] = 1'b1;
    @(posedge clk_i);
    vinsn_done_i <= mask;
    @(posedge clk_i);
    vinsn_done_i <= '0;
  endtask

  task automatic retire_lowest();
    int id;
    id = -1;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (m_running[i]) id = i;
    end
    if (id >= 0) retire(id);
  endtask

  task automatic drain();
    int n;
    for (int i = 0; i < NR_VINSN; i++) begin
      if (m_running[i]) retire(i);
    end
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > WAIT_LIMIT) fail_timeout("sequencer did not go idle");
    end while (!idle_o);
  endtask

  task automatic wait_resp(logic [SCALAR_W-1:0] data);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > WAIT_LIMIT) fail_timeout("no scalar response");
    end while (!resp_valid_o);
    check("resp_data_o", resp_data_o, data);
  endtask

  // Operand use follows the opcode, registers come from a small window to force hazards
  task automatic rand_req();
    op_e                 op;
    int                  vd;
    int                  vs1;
    int                  vs2;
    bit                  uvd;
    bit                  uvs1;
    bit                  uvs2;
    bit                  vm;
    int                  id;
    int                  n;
    logic [NR_VINSN-1:0] haz;
    op   = op_e'(3'($urandom_range(4)));
    vd   = int'($urandom_range(7));
    vs1  = int'($urandom_range(7));
    vs2  = int'($urandom_range(7));
    vm   = ($urandom_range(3) != 0);
    uvd  = (op != OP_STORE);
    uvs1 = (op == OP_ADD) || (op == OP_MUL) || (op == OP_STORE);
    uvs2 = (op == OP_ADD) || (op == OP_MUL) || (op == OP_SLIDEUP);
    if ($urandom_range(2) == 0) retire_lowest();
    // Free whatever blocks the request so the run never stalls
    n = 0;
    while (!ref_issue(op, vd, vs1, vs2, uvd, uvs1, uvs2, vm, id, haz)) begin
      retire_lowest();
      n++;
      if (n > NR_VINSN) fail_timeout("random request stayed blocked");
    end
    send_req(op, vd, vs1, vs2, uvd, uvs1, uvs2, vm);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int                  err0;
    int                  id_a;
    int                  seed;
    logic [SCALAR_W-1:0] data;
    seed           = $urandom(16428);
    rst_ni         = 1'b0;
    req_valid_i    = 1'b0;
    req_op_i       = OP_ADD;
    req_vd_i       = '0;
    req_vs1_i      = '0;
    req_vs2_i      = '0;
    req_use_vd_i   = 1'b0;
    req_use_vs1_i  = 1'b0;
    req_use_vs2_i  = 1'b0;
    req_vm_i       = 1'b1;
    vinsn_done_i   = '0;
    scalar_valid_i = 1'b0;
    scalar_data_i  = '0;
    errors         = 0;
    checks         = 0;
    acc_count      = 0;
    resp_pend      = 1'b0;
    model_reset();
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    err0 = errors;
    @(negedge clk_i);
    check("idle_o", 64'(idle_o), 64'(1));
    check("issue_valid_o", 64'(issue_valid_o), 64'(0));
    check("resp_valid_o", 64'(resp_valid_o), 64'(0));
    check("req_ready_o", 64'(req_ready_o), 64'(1));
    end_test("reset", err0);

    // Eight IDs spread over ALU and MUL, then a ninth waits for a free ID
    err0 = errors;
    for (int i = 0; i < 4; i++) send_req(OP_ADD, 0, 0, 0, 0, 0, 0, 1);
    for (int i = 0; i < 4; i++) send_req(OP_MUL, 0, 0, 0, 0, 0, 0, 1);
    start_req(OP_LOAD, 0, 0, 0, 0, 0, 0, 1);
    hold_stalled(5);
    retire(5);
    wait_accept();
    @(negedge clk_i);
    check("issue_id_o", 64'(issue_id_o), 64'(5));
    drain();
    end_test("id_alloc", err0);

    err0 = errors;
    for (int k = 0; k < RAND_INSNS; k++) rand_req();
    drain();
    end_test("random", err0);

    // SLIDE holds one instruction and LOAD two
    err0 = errors;
    send_req(OP_SLIDEUP, 10, 0, 11, 1, 0, 1, 1);
    id_a = last_acc_id;
    start_req(OP_SLIDEUP, 12, 0, 13, 1, 0, 1, 1);
    hold_stalled(4);
    retire(id_a);
    wait_accept();
    drain();
    send_req(OP_LOAD, 14, 0, 0, 1, 0, 0, 1);
    id_a = last_acc_id;
    send_req(OP_LOAD, 15, 0, 0, 1, 0, 0, 1);
    start_req(OP_LOAD, 16, 0, 0, 1, 0, 0, 1);
    hold_stalled(4);
    retire(id_a);
    wait_accept();
    drain();
    end_test("queue_full", err0);

    // A slide-up that overwrites a running add's result waits for that add
    err0 = errors;
    send_req(OP_ADD, 20, 21, 22, 1, 1, 1, 1);
    id_a = last_acc_id;
    start_req(OP_SLIDEUP, 20, 0, 23, 1, 0, 1, 1);
    hold_stalled(4);
    retire(id_a);
    wait_accept();
    @(negedge clk_i);
    check("issue_valid_o", 64'(issue_valid_o), 64'(1));
    check("issue_hazard_o", 64'(issue_hazard_o), 64'(0));
    drain();
    end_test("slide_hazard", err0);

    err0 = errors;
    send_req(OP_MVXS, 0, 0, 5, 0, 0, 1, 1);
    start_req(OP_ADD, 1, 2, 3, 1, 1, 1, 1);
    hold_stalled(6);
    data = {$urandom, $urandom};
    @(posedge clk_i);
    scalar_valid_i <= 1'b1;
    scalar_data_i  <= data;
    @(posedge clk_i);
    scalar_valid_i <= 1'b0;
    wait_resp(data);
    wait_accept();
    drain();
    end_test("scalar_move", err0);

    $display("[DONE] tests=6 checks=%0d errors=%0d issued=%0d seed=%0d", checks, errors,
             acc_count, seed);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
